// ==== verilog/alu_imm_settings.svh ====
// sizes for the ALU-immediate cluster
// every LOG_* value must equal log2 of its count; IQ_DEPTH must be a power of two
`ifndef ALU_IMM_SETTINGS_SVH
`define ALU_IMM_SETTINGS_SVH

// physical register file
`define PR_COUNT 16
`define LOG_PR_COUNT 4
`define PRF_BANK_COUNT 2
`define LOG_PRF_BANK_COUNT 1

// reorder buffer
`define ROB_ENTRIES 8
`define LOG_ROB_ENTRIES 3

// issue queue
`define IQ_DEPTH 4

`endif

// ==== verilog/core_types_pkg.sv ====
// types shared by the ALU-immediate cluster
// field widths follow alu_imm_settings.svh
`include "alu_imm_settings.svh"

package core_types_pkg;

    // funct3 in the low bits, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

    typedef struct packed {
        alu_op_e                      op;
        logic [11:0]                  imm12;
        logic [`LOG_PR_COUNT-1:0]     src_pr;
        logic [`LOG_PR_COUNT-1:0]     dest_pr;
        logic [`LOG_ROB_ENTRIES-1:0]  rob_index;
    } dispatch_t;

    typedef struct packed {
        alu_op_e                        op;
        logic [11:0]                    imm12;
        logic                           a_forward;
        logic [`LOG_PRF_BANK_COUNT-1:0] a_bank;
        logic [`LOG_PR_COUNT-1:0]       a_pr;
        logic [`LOG_PR_COUNT-1:0]       dest_pr;
        logic [`LOG_ROB_ENTRIES-1:0]    rob_index;
    } issue_t;

    typedef struct packed {
        logic [31:0]                  data;
        logic [`LOG_PR_COUNT-1:0]     pr;
        logic [`LOG_ROB_ENTRIES-1:0]  rob_index;
    } wb_t;

endpackage

// ==== verilog/alu.sv ====
// combinational 32-bit integer ALU
// unused opcode encodings behave as ADD
`timescale 1ns/1ns

module alu (
    input  core_types_pkg::alu_op_e op,
    input  logic [31:0]             A,
    input  logic [31:0]             B,
    output logic [31:0]             out
);
    import core_types_pkg::*;

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = B[4:0];

    always_comb begin
        case (op)
            ADD:     out = A + B;
            SUB:     out = A - B;
            SLL:     out = A << shamt;
            SLT:     out = {31'b0, $signed(A) < $signed(B)};
            SLTU:    out = {31'b0, A < B};
            XOR:     out = A ^ B;
            SRL:     out = A >> shamt;
            SRA:     out = $signed(A) >>> shamt;
            OR:      out = A | B;
            AND:     out = A & B;
            default: out = A + B;
        endcase
    end

endmodule

// ==== verilog/alu_imm_iq.sv ====
// in-order issue queue for register-immediate ops
// assumes renamed registers: dest_pr differs from src_pr and from every
// in-flight dest, otherwise the ready table stalls or releases too early
`timescale 1ns/1ns
`include "alu_imm_settings.svh"

module alu_imm_iq (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          dispatch_valid,
    input  core_types_pkg::dispatch_t     dispatch,
    output logic                          dispatch_ready,
    output logic                          issue_valid,
    output core_types_pkg::issue_t        issue,
    input  logic                          issue_ready,
    output logic                          read_req,
    output logic [`LOG_PR_COUNT-1:0]      read_pr,
    input  logic                          wb_fire,
    input  logic [`LOG_PR_COUNT-1:0]      wb_pr
);
    import core_types_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    dispatch_t              entries [`IQ_DEPTH];
    dispatch_t              head;
    logic [PTR_W-1:0]       head_ptr;
    logic [PTR_W-1:0]       tail_ptr;
    logic [PTR_W:0]         count;
    logic [`PR_COUNT-1:0]   pr_ready;
    logic                   src_ready;
    logic                   src_fwd;
    logic                   dispatch_fire;
    logic                   issue_fire;

    // ------------------------------------------------------------
    // queue storage

    assign dispatch_ready = (count != (PTR_W+1)'(`IQ_DEPTH));
    assign dispatch_fire = dispatch_valid & dispatch_ready;
    assign head = entries[head_ptr];

    always_ff @(posedge CLK) begin
        if (dispatch_fire) begin
            entries[tail_ptr] <= dispatch;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end else begin
            if (dispatch_fire) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (issue_fire) begin
                head_ptr <= head_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, dispatch_fire}
                           - {{PTR_W{1'b0}}, issue_fire};
        end
    end

    // ------------------------------------------------------------
    // ready table, one bit per physical register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            pr_ready <= '1;
        end else begin
            if (wb_fire) begin
                pr_ready[wb_pr] <= 1'b1;
            end
            // a new producer wins over a same-cycle writeback
            if (dispatch_fire) begin
                pr_ready[dispatch.dest_pr] <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // head issue

    assign src_ready = pr_ready[head.src_pr];
    // source written this cycle, value comes from the forward path
    assign src_fwd = ~src_ready & wb_fire & (wb_pr == head.src_pr);

    assign issue_valid = (count != '0) & (src_ready | src_fwd);
    assign issue_fire = issue_valid & issue_ready;

    assign issue.op = head.op;
    assign issue.imm12 = head.imm12;
    assign issue.a_forward = src_fwd;
    assign issue.a_bank = head.src_pr[`LOG_PRF_BANK_COUNT-1:0];
    assign issue.a_pr = head.src_pr;
    assign issue.dest_pr = head.dest_pr;
    assign issue.rob_index = head.rob_index;

    // PRF read only when the operand is not forwarded
    assign read_req = issue_fire & ~src_fwd;
    assign read_pr = issue.a_pr;

endmodule

// ==== verilog/prf.sv ====
// banked physical register file, two access ports per bank
// port 0 goes to the debug read first, a write takes one port of its bank,
// the pending operand read waits for whatever port is left
`timescale 1ns/1ns
`include "alu_imm_settings.svh"

module prf (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        read_req,
    input  logic [`LOG_PR_COUNT-1:0]                    read_pr,
    output logic                                        A_reg_read_ack,
    output logic                                        A_reg_read_port,
    output logic [`PRF_BANK_COUNT-1:0][1:0][31:0]       reg_read_data_by_bank_by_port,
    output logic [`PRF_BANK_COUNT-1:0][31:0]            forward_data_by_bank,
    input  logic                                        wb_fire,
    input  core_types_pkg::wb_t                         wb,
    input  logic                                        dbg_rd_valid,
    input  logic [`LOG_PR_COUNT-1:0]                    dbg_rd_pr,
    output logic [31:0]                                 dbg_rd_data
);
    localparam int ROWS = `PR_COUNT / `PRF_BANK_COUNT;
    localparam int ROW_W = `LOG_PR_COUNT - `LOG_PRF_BANK_COUNT;

    logic [31:0]                        regs [`PRF_BANK_COUNT][ROWS];
    logic                               pend_valid;
    logic [`LOG_PR_COUNT-1:0]           pend_pr;
    logic [`LOG_PRF_BANK_COUNT-1:0]     pend_bank;
    logic [`LOG_PRF_BANK_COUNT-1:0]     dbg_bank;
    logic [`LOG_PRF_BANK_COUNT-1:0]     wr_bank;
    logic [`PRF_BANK_COUNT-1:0]         dbg_hit;
    logic [`PRF_BANK_COUNT-1:0]         wr_hit;
    logic [`PRF_BANK_COUNT-1:0][1:0]    ports_used;

    assign pend_bank = pend_pr[`LOG_PRF_BANK_COUNT-1:0];
    assign dbg_bank = dbg_rd_pr[`LOG_PRF_BANK_COUNT-1:0];
    assign wr_bank = wb.pr[`LOG_PRF_BANK_COUNT-1:0];

    // ------------------------------------------------------------
    // port arbitration

    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            dbg_hit[b] = dbg_rd_valid & (dbg_bank == b[`LOG_PRF_BANK_COUNT-1:0]);
            wr_hit[b] = wb_fire & (wr_bank == b[`LOG_PRF_BANK_COUNT-1:0]);
            ports_used[b] = {1'b0, dbg_hit[b]} + {1'b0, wr_hit[b]};
        end
    end

    // lowest free port, none when both are taken
    assign A_reg_read_ack = pend_valid & (ports_used[pend_bank] != 2'd2);
    assign A_reg_read_port = ports_used[pend_bank][0];

    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            if (dbg_hit[b]) begin
                reg_read_data_by_bank_by_port[b][0] = regs[b][dbg_rd_pr[`LOG_PR_COUNT-1 -: ROW_W]];
            end else begin
                reg_read_data_by_bank_by_port[b][0] = regs[b][pend_pr[`LOG_PR_COUNT-1 -: ROW_W]];
            end
            reg_read_data_by_bank_by_port[b][1] = regs[b][pend_pr[`LOG_PR_COUNT-1 -: ROW_W]];
        end
    end

    // pending operand read, held until a port frees up
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            pend_valid <= 1'b0;
            pend_pr <= '0;
        end else if (read_req) begin
            pend_valid <= 1'b1;
            pend_pr <= read_pr;
        end else if (A_reg_read_ack) begin
            pend_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // write port, registers all start at zero

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
                for (int r = 0; r < ROWS; r++) begin
                    regs[b][r] <= 32'h0;
                end
            end
        end else if (wb_fire) begin
            regs[wr_bank][wb.pr[`LOG_PR_COUNT-1 -: ROW_W]] <= wb.data;
        end
    end

    // last write per bank feeds the forward path one cycle later
    always_ff @(posedge CLK) begin
        if (wb_fire) begin
            forward_data_by_bank[wr_bank] <= wb.data;
        end
        if (dbg_rd_valid) begin
            dbg_rd_data <= reg_read_data_by_bank_by_port[dbg_bank][0];
        end
    end

endmodule

// ==== verilog/alu_imm_pipeline.sv ====
// OC/EX/WB pipeline for register-immediate ALU ops
// operand A comes saved, forwarded or from a PRF read port; B is the immediate
// a stall in WB travels back one stage per valid stage
`timescale 1ns/1ns
`include "alu_imm_settings.svh"

module alu_imm_pipeline (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    issue_valid,
    input  core_types_pkg::issue_t                  issue,
    output logic                                    issue_ready,
    input  logic                                    A_reg_read_ack,
    input  logic                                    A_reg_read_port,
    input  logic [`PRF_BANK_COUNT-1:0][1:0][31:0]   reg_read_data_by_bank_by_port,
    input  logic [`PRF_BANK_COUNT-1:0][31:0]        forward_data_by_bank,
    output logic                                    WB_valid,
    output core_types_pkg::wb_t                     wb,
    input  logic                                    WB_ready
);
    import core_types_pkg::*;

    logic stall_wb;
    logic stall_ex;
    logic stall_oc;

    // OC stage
    logic                               valid_oc;
    logic                               a_saved_oc;
    logic                               a_forward_oc;
    logic [31:0]                        a_saved_data_oc;
    alu_op_e                            op_oc;
    logic [11:0]                        imm12_oc;
    logic [`LOG_PRF_BANK_COUNT-1:0]     a_bank_oc;
    logic [`LOG_PR_COUNT-1:0]           dest_pr_oc;
    logic [`LOG_ROB_ENTRIES-1:0]        rob_index_oc;
    logic                               a_present_oc;
    logic                               launch_oc;
    logic [31:0]                        next_a_ex;

    // EX stage
    logic                               valid_ex;
    alu_op_e                            op_ex;
    logic [31:0]                        a_ex;
    logic [31:0]                        b_ex;
    logic [11:0]                        imm12_ex;
    logic [`LOG_PR_COUNT-1:0]           dest_pr_ex;
    logic [`LOG_ROB_ENTRIES-1:0]        rob_index_ex;
    logic [31:0]                        alu_out_ex;

    // ------------------------------------------------------------
    // back-pressure

    assign stall_wb = WB_valid & ~WB_ready;
    assign stall_ex = valid_ex & stall_wb;
    assign stall_oc = valid_oc & stall_ex;

    // ------------------------------------------------------------
    // OC, wait for operand A

    assign a_present_oc = a_saved_oc | a_forward_oc | A_reg_read_ack;
    assign launch_oc = ~stall_oc & a_present_oc;
    assign issue_ready = ~valid_oc | launch_oc;

    always_comb begin
        if (a_saved_oc) begin
            next_a_ex = a_saved_data_oc;
        end else if (a_forward_oc) begin
            next_a_ex = forward_data_by_bank[a_bank_oc];
        end else begin
            next_a_ex = reg_read_data_by_bank_by_port[a_bank_oc][A_reg_read_port];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_oc <= 1'b0;
            a_saved_oc <= 1'b0;
            a_forward_oc <= 1'b0;
        end else if (issue_ready) begin
            valid_oc <= issue_valid;
            a_saved_oc <= 1'b0;
            a_forward_oc <= issue.a_forward;
        end else begin
            // forward data lasts one cycle, keep what arrived
            a_saved_oc <= a_present_oc;
            a_forward_oc <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc <= issue.op;
            imm12_oc <= issue.imm12;
            a_bank_oc <= issue.a_bank;
            dest_pr_oc <= issue.dest_pr;
            rob_index_oc <= issue.rob_index;
        end
        a_saved_data_oc <= next_a_ex;
    end

    // ------------------------------------------------------------
    // EX

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_ex <= 1'b0;
        end else if (~stall_ex) begin
            valid_ex <= valid_oc & launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_ex) begin
            op_ex <= op_oc;
            a_ex <= next_a_ex;
            imm12_ex <= imm12_oc;
            dest_pr_ex <= dest_pr_oc;
            rob_index_ex <= rob_index_oc;
        end
    end

    // sign-extended immediate
    assign b_ex = {{20{imm12_ex[11]}}, imm12_ex};

    alu u_alu (
        .op  (op_ex),
        .A   (a_ex),
        .B   (b_ex),
        .out (alu_out_ex)
    );

    // ------------------------------------------------------------
    // WB, held while the consumer is not ready

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            WB_valid <= 1'b0;
        end else if (~stall_wb) begin
            WB_valid <= valid_ex;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_wb) begin
            wb.data <= alu_out_ex;
            wb.pr <= dest_pr_ex;
            wb.rob_index <= rob_index_ex;
        end
    end

endmodule

// ==== verilog/alu_imm_cluster.sv ====
// ALU-immediate cluster: issue queue, OC/EX/WB pipeline and banked PRF
// a completion counts in a cycle with complete_valid and complete_ready high
`timescale 1ns/1ns
`include "alu_imm_settings.svh"

module alu_imm_cluster (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          dispatch_valid,
    input  core_types_pkg::dispatch_t     dispatch,
    output logic                          dispatch_ready,
    input  logic                          complete_ready,
    output logic                          complete_valid,
    output core_types_pkg::wb_t           complete,
    input  logic                          dbg_rd_valid,
    input  logic [`LOG_PR_COUNT-1:0]      dbg_rd_pr,
    output logic [31:0]                   dbg_rd_data
);
    import core_types_pkg::*;

    logic                                   issue_valid;
    issue_t                                 issue;
    logic                                   issue_ready;
    logic                                   read_req;
    logic [`LOG_PR_COUNT-1:0]               read_pr;
    logic                                   A_reg_read_ack;
    logic                                   A_reg_read_port;
    logic [`PRF_BANK_COUNT-1:0][1:0][31:0]  reg_read_data_by_bank_by_port;
    logic [`PRF_BANK_COUNT-1:0][31:0]       forward_data_by_bank;
    logic                                   WB_valid;
    wb_t                                    wb;
    logic                                   wb_fire;

    // the write and the completion happen together
    assign wb_fire = WB_valid & complete_ready;
    assign complete_valid = WB_valid;
    assign complete = wb;

    alu_imm_iq u_iq (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .read_req       (read_req),
        .read_pr        (read_pr),
        .wb_fire        (wb_fire),
        .wb_pr          (wb.pr)
    );

    alu_imm_pipeline u_pipeline (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue                         (issue),
        .issue_ready                   (issue_ready),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .WB_valid                      (WB_valid),
        .wb                            (wb),
        .WB_ready                      (complete_ready)
    );

    prf u_prf (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .read_req                      (read_req),
        .read_pr                       (read_pr),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .wb_fire                       (wb_fire),
        .wb                            (wb),
        .dbg_rd_valid                  (dbg_rd_valid),
        .dbg_rd_pr                     (dbg_rd_pr),
        .dbg_rd_data                   (dbg_rd_data)
    );

endmodule

// ==== bench/tb_alu_imm_cluster.sv ====
// testbench for the ALU-immediate cluster, stimulus from a table checked against a register model
// a dest register is never reused while an earlier op may still read or write it
`timescale 1ns/1ns
`include "alu_imm_settings.svh"

module tb_alu_imm_cluster;
    import core_types_pkg::*;

    localparam int TIMEOUT = 300;

    typedef struct packed {
        dispatch_t  op;
        logic       stall;
        logic       dbg;
    } stim_entry_t;

    logic                       CLK = 1'b0;
    logic                       nRST;
    logic                       dispatch_valid;
    dispatch_t                  dispatch;
    logic                       dispatch_ready;
    logic                       complete_ready = 1'b1;
    logic                       complete_valid;
    wb_t                        complete;
    logic                       dbg_rd_valid;
    logic [`LOG_PR_COUNT-1:0]   dbg_rd_pr;
    logic [31:0]                dbg_rd_data;

    stim_entry_t    stim [$];
    int             section_starts [$];
    wb_t            exp_q [$];
    logic [31:0]    model_regs [`PR_COUNT];
    logic [31:0]    done_regs [`PR_COUNT];
    logic           force_stall;
    logic           random_gaps;
    logic           dbg_pending = 1'b0;
    logic [31:0]    dbg_expect;
    logic           hold_valid = 1'b0;
    wb_t            hold_val;
    int             checks = 0;
    int             errors = 0;

    always #10 CLK = ~CLK;

    alu_imm_cluster u_dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .complete_ready (complete_ready),
        .complete_valid (complete_valid),
        .complete       (complete),
        .dbg_rd_valid   (dbg_rd_valid),
        .dbg_rd_pr      (dbg_rd_pr),
        .dbg_rd_data    (dbg_rd_data)
    );

    // ------------------------------------------------------------
    // reference model and helpers

    // immediate is sign-extended, shifts use its low five bits
    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [11:0] imm);
        logic [31:0] b;
        logic [31:0] r;
        b = {{20{imm[11]}}, imm};
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            SLL:     r = a << b[4:0];
            SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            XOR:     r = a ^ b;
            SRL:     r = a >> b[4:0];
            SRA:     r = $signed(a) >>> b[4:0];
            OR:      r = a | b;
            AND:     r = a & b;
            default: r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic dispatch_t make_op(input alu_op_e op, input logic [11:0] imm,
                                          input int src, input int dest, input int rob);
        dispatch_t d;
        d.op = op;
        d.imm12 = imm;
        d.src_pr = src[`LOG_PR_COUNT-1:0];
        d.dest_pr = dest[`LOG_PR_COUNT-1:0];
        d.rob_index = rob[`LOG_ROB_ENTRIES-1:0];
        return d;
    endfunction

    task automatic add_entry(input alu_op_e op, input logic [11:0] imm, input int src,
                             input int dest, input logic stall, input logic dbg);
        stim_entry_t e;
        e.op = make_op(op, imm, src, dest, stim.size());
        e.stall = stall;
        e.dbg = dbg;
        stim.push_back(e);
    endtask

    // the pipeline drains before the next entry is sent
    task automatic start_section;
        section_starts.push_back(stim.size());
    endtask

    function automatic logic starts_section(input int idx);
        logic found;
        found = 1'b0;
        foreach (section_starts[k]) begin
            if (section_starts[k] == idx) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic load_table;
        // every opcode, positive and negative immediates
        add_entry(ADD,  12'h123, 0, 1, 1'b0, 1'b0);
        add_entry(ADD,  12'hFFF, 0, 2, 1'b0, 1'b0);
        add_entry(ADD,  12'h800, 1, 3, 1'b0, 1'b0);
        add_entry(XOR,  12'h5A5, 3, 4, 1'b0, 1'b0);
        add_entry(OR,   12'h0F0, 1, 5, 1'b0, 1'b0);
        add_entry(AND,  12'hF0F, 3, 6, 1'b0, 1'b0);
        add_entry(SLT,  12'h001, 3, 7, 1'b0, 1'b0);
        add_entry(SLTU, 12'h001, 3, 8, 1'b0, 1'b0);
        add_entry(SLTU, 12'hFFF, 1, 9, 1'b0, 1'b0);
        add_entry(SLL,  12'h004, 1, 10, 1'b0, 1'b0);
        add_entry(SRL,  12'h008, 3, 11, 1'b0, 1'b0);
        add_entry(SRA,  12'h008, 3, 12, 1'b0, 1'b0);
        add_entry(SRA,  12'h41F, 2, 13, 1'b0, 1'b0);
        add_entry(SLT,  12'h7FF, 1, 14, 1'b0, 1'b0);
        add_entry(SUB,  12'h023, 1, 15, 1'b0, 1'b0);
        // dependent chain, each op reads the previous dest
        start_section();
        add_entry(ADD,  12'h001, 15, 1, 1'b0, 1'b0);
        add_entry(SLL,  12'h001, 1, 2, 1'b0, 1'b0);
        add_entry(XOR,  12'h7FF, 2, 3, 1'b0, 1'b0);
        add_entry(ADD,  12'hFFE, 3, 4, 1'b0, 1'b0);
        add_entry(SRA,  12'h002, 4, 5, 1'b0, 1'b0);
        add_entry(OR,   12'h300, 5, 6, 1'b0, 1'b0);
        // random gaps on complete_ready
        add_entry(ADD,  12'h010, 6, 7, 1'b1, 1'b0);
        add_entry(SUB,  12'h005, 7, 8, 1'b1, 1'b0);
        add_entry(ADD,  12'h111, 2, 9, 1'b1, 1'b0);
        add_entry(SRL,  12'h003, 8, 10, 1'b1, 1'b0);
        add_entry(AND,  12'h7F0, 9, 11, 1'b1, 1'b0);
        add_entry(SLTU, 12'h800, 10, 12, 1'b1, 1'b0);
        add_entry(XOR,  12'hABC, 11, 13, 1'b1, 1'b0);
        add_entry(ADD,  12'h001, 13, 14, 1'b1, 1'b0);
        // bank 0 only, debug reads compete with writes and operand reads
        start_section();
        add_entry(ADD,  12'h00A, 4, 2, 1'b0, 1'b1);
        add_entry(ADD,  12'h00B, 2, 6, 1'b0, 1'b1);
        add_entry(XOR,  12'h0FF, 4, 0, 1'b0, 1'b1);
        add_entry(SLL,  12'h002, 6, 8, 1'b0, 1'b1);
        add_entry(ADD,  12'hFF0, 0, 10, 1'b0, 1'b1);
        add_entry(OR,   12'h001, 8, 12, 1'b0, 1'b1);
        add_entry(SRL,  12'h001, 10, 14, 1'b0, 1'b1);
    endtask

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic send_op(input dispatch_t d, input logic dbg);
        int waited;
        logic [31:0] result;
        wb_t exp_wb;
        dispatch = d;
        dispatch_valid = 1'b1;
        dbg_rd_valid = dbg;
        dbg_rd_pr = d.src_pr;
        waited = 0;
        @(negedge CLK);
        while (!dispatch_ready && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (dispatch_ready) begin
            result = ref_alu(d.op, model_regs[d.src_pr], d.imm12);
            model_regs[d.dest_pr] = result;
            exp_wb.data = result;
            exp_wb.pr = d.dest_pr;
            exp_wb.rob_index = d.rob_index;
            exp_q.push_back(exp_wb);
        end else begin
            $display("timeout: dispatch of rob index %0d was never accepted", d.rob_index);
            errors++;
        end
        @(posedge CLK);
        #1;
        dispatch_valid = 1'b0;
        dbg_rd_valid = 1'b0;
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d completions never arrived", exp_q.size());
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // complete_ready driver

    always @(posedge CLK) begin
        #1;
        if (force_stall) begin
            complete_ready = 1'b0;
        end else if (random_gaps) begin
            complete_ready = (($urandom % 3) != 0);
        end else begin
            complete_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // monitor, samples mid-cycle

    always @(negedge CLK) begin
        wb_t exp_wb;
        if (!nRST) begin
            for (int r = 0; r < `PR_COUNT; r++) begin
                done_regs[r] = 32'h0;
            end
        end else begin
            // debug data shows the registers as they were one cycle ago
            if (dbg_pending) begin
                check("dbg_rd_data", dbg_rd_data, dbg_expect);
            end
            dbg_pending = dbg_rd_valid;
            if (dbg_rd_valid) begin
                dbg_expect = done_regs[dbg_rd_pr];
            end
            if (hold_valid) begin
                check("complete_valid", 32'(complete_valid), 32'd1);
                check("complete.data", complete.data, hold_val.data);
                check("complete.pr", 32'(complete.pr), 32'(hold_val.pr));
                check("complete.rob_index", 32'(complete.rob_index), 32'(hold_val.rob_index));
            end
            hold_valid = complete_valid & ~complete_ready;
            hold_val = complete;
            if (complete_valid & complete_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a completion arrived with no op outstanding");
                    errors++;
                end else begin
                    exp_wb = exp_q.pop_front();
                    check("complete.data", complete.data, exp_wb.data);
                    check("complete.pr", 32'(complete.pr), 32'(exp_wb.pr));
                    check("complete.rob_index", 32'(complete.rob_index),
                          32'(exp_wb.rob_index));
                    done_regs[exp_wb.pr] = exp_wb.data;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // main sequence

    initial begin
        int cycles;
        int accepted;
        logic full_seen;
        void'($urandom(32'h2720_b252));
        nRST = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        dbg_rd_valid = 1'b0;
        dbg_rd_pr = '0;
        force_stall = 1'b0;
        random_gaps = 1'b0;
        for (int r = 0; r < `PR_COUNT; r++) begin
            model_regs[r] = 32'h0;
        end
        load_table();
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        check("complete_valid", 32'(complete_valid), 32'd0);
        check("dispatch_ready", 32'(dispatch_ready), 32'd1);
        @(posedge CLK);
        #1;

        // single op, issue comes one cycle after acceptance
        send_op(make_op(ADD, 12'h055, 0, 1, 0), 1'b0);
        cycles = 0;
        @(negedge CLK);
        while (!complete_valid && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        check("issue to complete_valid cycles", cycles, 32'd3);
        wait_drain();
        @(posedge CLK);
        #1;

        // fill queue and pipeline with completions blocked
        force_stall = 1'b1;
        accepted = 0;
        full_seen = 1'b0;
        for (int i = 0; i < 10 && !full_seen; i++) begin
            dispatch = make_op(ADD, 12'(16 * i + 3), 0, i + 1, i + 1);
            dispatch_valid = 1'b1;
            @(negedge CLK);
            if (dispatch_ready) begin
                model_regs[i + 1] = ref_alu(ADD, model_regs[0], 12'(16 * i + 3));
                exp_q.push_back({model_regs[i + 1], dispatch.dest_pr, dispatch.rob_index});
                accepted++;
            end else begin
                full_seen = 1'b1;
            end
            @(posedge CLK);
            #1;
        end
        dispatch_valid = 1'b0;
        check("ops accepted while blocked", accepted, 32'(`IQ_DEPTH + 3));
        repeat (3) @(posedge CLK);
        #1;
        check("dispatch_ready", 32'(dispatch_ready), 32'd0);
        force_stall = 1'b0;
        wait_drain();
        @(posedge CLK);
        #1;

        for (int i = 0; i < stim.size(); i++) begin
            if (starts_section(i)) begin
                wait_drain();
                @(posedge CLK);
                #1;
            end
            random_gaps = stim[i].stall;
            send_op(stim[i].op, stim[i].dbg);
        end
        random_gaps = 1'b0;
        wait_drain();
        repeat (2) @(negedge CLK);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/core_types_pkg.sv
verilog/alu.sv
verilog/alu_imm_iq.sv
verilog/prf.sv
verilog/alu_imm_pipeline.sv
verilog/alu_imm_cluster.sv
bench/tb_alu_imm_cluster.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_alu_imm_cluster
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
